//--- tb/alloc_patterns.txt
# in_valid hop_n hop_s hop_w hop_e hop_l out_ready exp_out_valid win_n win_s win_w win_e win_l exp_in_ready
# masks in binary, local east west south north from left to right; win is the input per output, 7 = none
00000 0 0 0 0 0 11111 00000 7 7 7 7 7 00000
00000 0 0 0 0 0 00000 00000 7 7 7 7 7 00000
00001 1 0 0 0 0 11111 00010 7 0 7 7 7 00001
10000 0 0 0 0 2 11011 00100 7 7 4 7 7 00000
10000 0 0 0 0 2 11111 00100 7 7 4 7 7 10000
00010 0 1 0 0 0 11111 00000 7 7 7 7 7 00000
11000 0 0 0 3 4 11111 00000 7 7 7 7 7 00000
00010 0 0 0 0 0 11111 00001 1 7 7 7 7 00010
# four inputs contend for east
10111 3 3 3 0 3 11111 01000 7 7 7 0 7 00001
10111 3 3 3 0 3 11111 01000 7 7 7 1 7 00010
10111 3 3 3 0 3 11111 01000 7 7 7 2 7 00100
10111 3 3 3 0 3 11111 01000 7 7 7 4 7 10000
10111 3 3 3 0 3 11111 01000 7 7 7 0 7 00001
# east stalled
10111 3 3 3 0 3 10111 01000 7 7 7 1 7 00000
10111 3 3 3 0 3 10111 01000 7 7 7 1 7 00000
10111 3 3 3 0 3 11111 01000 7 7 7 1 7 00010
10111 3 3 3 0 3 10111 01000 7 7 7 2 7 00000
10111 3 3 3 0 3 11111 01000 7 7 7 2 7 00100
# every input to a different output
11111 3 2 4 0 1 11111 11111 3 4 1 0 2 11111
11111 3 3 0 2 0 11111 01101 4 7 3 1 7 11010
11111 3 3 0 2 0 11111 01101 2 7 3 0 7 01101
11111 3 3 0 2 0 11110 01101 4 7 3 1 7 01010
11111 3 3 0 2 0 11111 01101 4 7 3 0 7 11001
00000 0 0 0 0 0 11111 00000 7 7 7 7 7 00000
00000 1 0 3 4 2 11111 00000 7 7 7 7 7 00000
10001 4 0 0 0 4 11111 10000 7 7 7 7 0 00001
# four inputs contend for local
01111 4 4 4 4 0 11111 10000 7 7 7 7 1 00010
01111 4 4 4 4 0 01111 10000 7 7 7 7 2 00000
01111 4 4 4 4 0 11111 10000 7 7 7 7 2 00100
01111 4 4 4 4 0 11111 10000 7 7 7 7 3 01000
01111 4 4 4 4 0 11111 10000 7 7 7 7 0 00001
00000 0 0 0 0 0 11111 00000 7 7 7 7 7 00000

//--- project.f
src/noc_pkg.sv
src/route_comparator.sv
src/rr_priority_reg.sv
src/rr_port_arbiter.sv
src/flit_crossbar.sv
src/switch_allocator.sv
tb/tb_switch_allocator.sv

//--- Makefile
# Verilator build and run for the switch allocator testbench

VERILATOR ?= verilator
TOP       ?= tb_switch_allocator
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/tb_switch_allocator.sv
`timescale 1ns/1ns

module tb_switch_allocator
  import noc_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int MAX_VEC = 64;
  localparam int NO_WINNER = 7;
  localparam string PATTERN_FILE = "tb/alloc_patterns.txt";

  logic       clk;
  logic       rst_i;
  port_mask_t in_valid;
  flit_bus_t  in_flit;
  port_mask_t in_ready;
  port_mask_t out_valid;
  flit_bus_t  out_flit;
  port_mask_t out_ready;

  // pattern table, one entry per cycle
  port_mask_t vec_valid     [MAX_VEC];
  port_mask_t vec_ready     [MAX_VEC];
  port_mask_t vec_exp_valid [MAX_VEC];
  port_mask_t vec_exp_ready [MAX_VEC];
  dir_e       vec_hop       [MAX_VEC][NUM_PORTS];
  int         vec_winner    [MAX_VEC][NUM_PORTS];

  int          num_vec;
  int          checks_done;
  logic        loaded;
  logic [31:0] lfsr_state;

  // flits driven in the current cycle
  flit_bus_t stim_bus;

  switch_allocator dut (
    .clk         (clk),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid),
    .in_flit_i   (in_flit),
    .in_ready_o  (in_ready),
    .out_valid_o (out_valid),
    .out_flit_o  (out_flit),
    .out_ready_i (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // galois form, polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h80200003;
    end
    return state >> 1;
  endfunction

  // one lfsr step per payload bit
  task automatic next_payload(output flit_data_t data);
    for (int b = 0; b < FLIT_DATA_W; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      data[b] = lfsr_state[0];
    end
  endtask

  task automatic load_patterns();
    int         fd;
    int         n;
    int         hop [NUM_PORTS];
    int         win [NUM_PORTS];
    port_mask_t v;
    port_mask_t r;
    port_mask_t ev;
    port_mask_t er;
    string      line;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      $display("could not open the pattern file %s", PATTERN_FILE);
      $display("CHECKS FAILED");
      $fatal(1, "pattern file missing");
    end
    num_vec = 0;
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      // skip blank lines and comment lines
      if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%b %d %d %d %d %d %b %b %d %d %d %d %d %b",
                  v, hop[0], hop[1], hop[2], hop[3], hop[4], r,
                  ev, win[0], win[1], win[2], win[3], win[4], er);
      if (n != 14 || num_vec >= MAX_VEC) begin
        $display("bad or excess pattern line: %s", line);
        $display("CHECKS FAILED");
        $fatal(1, "pattern file format");
      end
      vec_valid[num_vec]     = v;
      vec_ready[num_vec]     = r;
      vec_exp_valid[num_vec] = ev;
      vec_exp_ready[num_vec] = er;
      for (int i = 0; i < NUM_PORTS; i++) begin
        vec_hop[num_vec][i]    = dir_e'(hop[i]);
        vec_winner[num_vec][i] = win[i];
      end
      num_vec++;
    end
    $fclose(fd);
  endtask

  task automatic build_flits(input int k);
    flit_data_t data;
    for (int i = 0; i < NUM_PORTS; i++) begin
      next_payload(data);
      stim_bus[i].next_hop = vec_hop[k][i];
      stim_bus[i].payload  = data;
    end
  endtask

  task automatic check_mask(input string what, input port_mask_t got, input port_mask_t exp);
    checks_done++;
    if (got !== exp) begin
      $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "mask mismatch");
    end
  endtask

  task automatic check_flit(input string what, input flit_t got, input flit_t exp);
    checks_done++;
    if (got !== exp) begin
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "flit mismatch");
    end
  endtask

  // expected flit is the winner's stimulus flit, zero when no winner
  task automatic check_vector(input int k);
    flit_t exp_flit;
    int    w;
    check_mask($sformatf("line %0d out_valid", k + 1), out_valid, vec_exp_valid[k]);
    check_mask($sformatf("line %0d in_ready", k + 1), in_ready, vec_exp_ready[k]);
    for (int o = 0; o < NUM_PORTS; o++) begin
      w = vec_winner[k][o];
      if (w == NO_WINNER) begin
        exp_flit = '0;
      end else begin
        exp_flit = stim_bus[w];
      end
      check_flit($sformatf("line %0d out_flit[%0d]", k + 1, o), out_flit[o], exp_flit);
    end
  endtask

  initial begin
    in_valid    = '0;
    in_flit     = '0;
    out_ready   = '0;
    rst_i       = 1'b1;
    loaded      = 1'b0;
    checks_done = 0;
    lfsr_state  = 32'hd749ec90;
    stim_bus    = '0;
    load_patterns();
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    rst_i <= 1'b0;
    for (int k = 0; k < num_vec; k++) begin
      @(posedge clk);
      build_flits(k);
      in_valid  <= vec_valid[k];
      in_flit   <= stim_bus;
      out_ready <= vec_ready[k];
      // outputs settle well before the falling edge
      @(negedge clk);
      check_vector(k);
    end
    @(posedge clk);
    if (checks_done > 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("no pattern lines were checked");
      $display("CHECKS FAILED");
      $fatal(1, "empty pattern file");
    end
  end

  // run length is reset plus one cycle per line, with margin
  initial begin
    wait (loaded);
    #((num_vec + 10) * CLK_PERIOD);
    $display("watchdog expired, the simulation timed out");
    $display("CHECKS FAILED");
    $fatal(1, "timeout");
  end

endmodule

//--- src/switch_allocator.sv
`timescale 1ns/1ns

module switch_allocator
  import noc_pkg::*;
(
  input  logic       clk,
  input  logic       rst_i,

  // input ports, from the router input stage
  input  port_mask_t in_valid_i,
  input  flit_bus_t  in_flit_i,
  output port_mask_t in_ready_o,

  // output ports, toward the downstream links
  output port_mask_t out_valid_o,
  output flit_bus_t  out_flit_o,
  input  port_mask_t out_ready_i
);

  // request columns, indexed by output then input
  port_mask_t [NUM_PORTS-1:0] req_matrix;

  // per-output one-hot grants, each slice driven by its own arbiter
  wire port_mask_t [NUM_PORTS-1:0] grant_matrix;

  // per-output valid bits
  wire port_mask_t arb_valid;

  route_comparator u_cmp (
    .in_valid_i   (in_valid_i),
    .in_flit_i    (in_flit_i),
    .req_matrix_o (req_matrix)
  );

  // one arbiter for each dir_e value
  for (genvar o = 0; o < NUM_PORTS; o++) begin : g_arb
    rr_port_arbiter u_arb (
      .clk         (clk),
      .rst_i       (rst_i),
      .req_i       (req_matrix[o]),
      .out_ready_i (out_ready_i[o]),
      .grant_o     (grant_matrix[o]),
      .out_valid_o (arb_valid[o])
    );
  end

  flit_crossbar u_xbar (
    .grant_i    (grant_matrix),
    .in_flit_i  (in_flit_i),
    .out_flit_o (out_flit_o)
  );

  assign out_valid_o = arb_valid;

  // an input is ready when its granted output accepts this cycle
  // each input requests one output at most, so only one term can fire
  always_comb begin
    in_ready_o = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        in_ready_o[i] = in_ready_o[i] | (grant_matrix[o][i] & out_ready_i[o]);
      end
    end
  end

endmodule

//--- src/flit_crossbar.sv
`timescale 1ns/1ns

module flit_crossbar
  import noc_pkg::*;
(
  input  port_mask_t [NUM_PORTS-1:0] grant_i,
  input  flit_bus_t                  in_flit_i,
  output flit_bus_t                  out_flit_o
);

  localparam int FLIT_W = $bits(flit_t);

  // input flits flattened for the and-or network
  logic [NUM_PORTS-1:0][FLIT_W-1:0] in_bits;

  // accumulated output per direction
  logic [NUM_PORTS-1:0][FLIT_W-1:0] out_bits;

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      in_bits[i] = in_flit_i[i];
    end
  end

  // one-hot select, so at most one term survives per output
  // an output with no grant collapses to all zeros
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      out_bits[o] = '0;
      for (int i = 0; i < NUM_PORTS; i++) begin
        out_bits[o] = out_bits[o] | (in_bits[i] & {FLIT_W{grant_i[o][i]}});
      end
    end
  end

  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      out_flit_o[o] = flit_t'(out_bits[o]);
    end
  end

endmodule

//--- src/rr_port_arbiter.sv
`timescale 1ns/1ns

module rr_port_arbiter
  import noc_pkg::*;
(
  input  logic       clk,
  input  logic       rst_i,
  input  port_mask_t req_i,
  input  logic       out_ready_i,
  output port_mask_t grant_o,
  output logic       out_valid_o
);

  // isolate the lowest set bit of a mask
  function automatic port_mask_t lowest_one(port_mask_t vec);
    port_mask_t neg;
    neg = ~vec + port_mask_t'(1);
    return vec & neg;
  endfunction

  port_mask_t token;

  // positions at or after the token in direction order
  port_mask_t at_or_after;

  // requests still ahead of the token, and the first one among them
  port_mask_t req_upper;
  port_mask_t pick_upper;

  // wrapped search, first requester counting from north
  port_mask_t pick_wrap;

  logic any_req;
  logic any_upper;
  logic accept;

  // token is one-hot, so token - 1 marks everything below it
  always_comb begin
    at_or_after = ~(token - port_mask_t'(1));
    req_upper   = req_i & at_or_after;
    any_upper   = |req_upper;
    any_req     = |req_i;
  end

  always_comb begin
    pick_upper = lowest_one(req_upper);
    pick_wrap  = lowest_one(req_i);
  end

  // nothing ahead of the token means the search wraps past local
  always_comb begin
    if (any_upper) begin
      grant_o = pick_upper;
    end else begin
      grant_o = pick_wrap;
    end
  end

  // grant stays stable while requests and token are unchanged
  assign out_valid_o = any_req;
  assign accept      = any_req & out_ready_i;

  rr_priority_reg u_prio (
    .clk       (clk),
    .rst_i     (rst_i),
    .advance_i (accept),
    .winner_i  (grant_o),
    .token_o   (token)
  );

endmodule

//--- src/rr_priority_reg.sv
`timescale 1ns/1ns

module rr_priority_reg
  import noc_pkg::*;
(
  input  logic       clk,
  input  logic       rst_i,
  input  logic       advance_i,
  input  port_mask_t winner_i,
  output port_mask_t token_o
);

  // north holds top priority out of reset
  localparam port_mask_t TOKEN_INIT = port_mask_t'(1) << DIR_NORTH;

  port_mask_t token_q;
  port_mask_t token_d;
  port_mask_t winner_next;
  logic       winner_seen;

  // direction just after the winner, local wraps back to north
  always_comb begin
    winner_next = {winner_i[NUM_PORTS-2:0], winner_i[NUM_PORTS-1]};
    winner_seen = |winner_i;
  end

  // token only moves on an accepted transfer
  always_comb begin
    token_d = token_q;
    if (advance_i && winner_seen) begin
      token_d = winner_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      token_q <= TOKEN_INIT;
    end else begin
      token_q <= token_d;
    end
  end

  assign token_o = token_q;

endmodule

//--- src/route_comparator.sv
`timescale 1ns/1ns

module route_comparator
  import noc_pkg::*;
(
  input  port_mask_t                   in_valid_i,
  input  flit_bus_t                    in_flit_i,
  output port_mask_t [NUM_PORTS-1:0]   req_matrix_o
);

  // next-hop match with u-turns removed, before valid masking
  // hop_match[o][i] set when input i names output o from another side
  port_mask_t [NUM_PORTS-1:0] hop_match;

  // an output never serves the input on its own side
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        hop_match[o][i] = (i != o) && (in_flit_i[i].next_hop == dir_e'(o));
      end
    end
  end

  // codes 5..7 match no output, so such flits raise no request
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      req_matrix_o[o] = hop_match[o] & in_valid_i;
    end
  end

endmodule

//--- src/noc_pkg.sv
package noc_pkg;

  // mesh router port count, fixed by the topology
  localparam int NUM_PORTS = 5;

  // payload bits carried by one flit
  localparam int FLIT_DATA_W = 16;

  // width of a direction code
  localparam int DIR_W = 3;

  // router port names, also used as bit and array indices
  typedef enum logic [DIR_W-1:0] {
    DIR_NORTH = 3'd0,
    DIR_SOUTH = 3'd1,
    DIR_WEST  = 3'd2,
    DIR_EAST  = 3'd3,
    DIR_LOCAL = 3'd4
  } dir_e;

  // one bit per direction, indexed by dir_e
  // used for requests, grants, valids and readies
  typedef logic [NUM_PORTS-1:0] port_mask_t;

  // flit payload
  typedef logic [FLIT_DATA_W-1:0] flit_data_t;

  // single flit as it arrives at the stage
  typedef struct packed {
    dir_e       next_hop;
    flit_data_t payload;
  } flit_t;

  // one flit per router port
  typedef flit_t [NUM_PORTS-1:0] flit_bus_t;

endpackage
